//--- hdl/cache_pkg.sv
// Widths, payload structs and cache states shared by every block of the memory subsystem
package cache_pkg;

    localparam int WORD_BITS      = 32;
    localparam int WORDS_PER_LINE = 4;
    localparam int WSEL_BITS      = 2;

    // Memory tag layout
    localparam int BYPASS_BIT = 7;
    localparam int PORT_BIT   = 6;

    typedef logic [WORD_BITS-1:0]                word_t;
    typedef logic [WORD_BITS/8-1:0]              byteen_t;
    typedef logic [15:0]                         word_addr_t;
    typedef logic [15-WSEL_BITS:0]               line_addr_t;
    typedef logic [WORDS_PER_LINE*WORD_BITS-1:0] line_t;
    typedef logic [WORDS_PER_LINE*WORD_BITS/8-1:0] line_byteen_t;
    typedef logic [3:0]                          core_tag_t;
    typedef logic [7:0]                          mem_tag_t;

    typedef struct packed {
        logic       rw;
        logic       io;
        word_addr_t addr;
        word_t      data;
        byteen_t    byteen;
        core_tag_t  tag;
    } core_req_t;

    typedef struct packed {
        word_t     data;
        core_tag_t tag;
    } core_rsp_t;

    typedef struct packed {
        logic         rw;
        line_addr_t   addr;
        line_t        data;
        line_byteen_t byteen;
        mem_tag_t     tag;
    } mem_req_t;

    typedef struct packed {
        line_t    data;
        mem_tag_t tag;
    } mem_rsp_t;

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        FILL_REQ,
        FILL_WAIT,
        WRITE_REQ,
        WRITE_WAIT
    } cache_state_e;

endpackage

//--- hdl/req_arbiter.sv
// Round-robin arbiter used by the io bypass path and by the cache front end
`timescale 1ns/1ps

module req_arbiter #(
    parameter int  NUM_PORTS = 2,
    localparam int IDX_W     = (NUM_PORTS > 1) ? $clog2(NUM_PORTS) : 1
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic [NUM_PORTS-1:0] requests,
    output logic [IDX_W-1:0]     grant_index,
    output logic [NUM_PORTS-1:0] grant_onehot,
    output logic                 grant_valid,
    input  logic                 grant_ready
);

    logic [IDX_W-1:0] last_idx;

    // Search starts just after the last port served
    always_comb begin
        logic found;
        int   j;
        found = 1'b0;
        grant_index = '0;
        for (int k = 1; k <= NUM_PORTS; k++) begin
            j = (int'(last_idx) + k) % NUM_PORTS;
            if (!found && requests[j]) begin
                found = 1'b1;
                grant_index = IDX_W'(j);
            end
        end
    end

    assign grant_valid  = |requests;
    assign grant_onehot = grant_valid ? (NUM_PORTS'(1) << grant_index) : '0;

    always_ff @(posedge clk) begin
        if (rst) begin
            last_idx <= IDX_W'(NUM_PORTS - 1);
        end else if (grant_valid && grant_ready) begin
            last_idx <= grant_index;
        end
    end

endmodule

//--- hdl/elastic_buffer.sv
// Two-entry valid/ready skid buffer with registered data, valid and ready outputs
`timescale 1ns/1ps

module elastic_buffer #(
    parameter int DATAW = 8
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             valid_in,
    output logic             ready_in,
    input  logic [DATAW-1:0] data_in,
    output logic             valid_out,
    input  logic             ready_out,
    output logic [DATAW-1:0] data_out
);

    logic [DATAW-1:0] main_q;
    logic [DATAW-1:0] skid_q;
    logic             main_v;
    logic             skid_v;
    logic             main_load;

    // Main register may take new data when empty or draining
    assign main_load = ready_out || !main_v;

    assign ready_in  = !skid_v;
    assign valid_out = main_v;
    assign data_out  = main_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            main_v <= 1'b0;
            skid_v <= 1'b0;
        end else if (main_load) begin
            main_v <= skid_v || valid_in;
            skid_v <= 1'b0;
        end else if (valid_in && !skid_v) begin
            skid_v <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (main_load) begin
            main_q <= skid_v ? skid_q : data_in;
        end
        // Overflow entry while the output is stalled
        if (!main_load && valid_in && !skid_v) begin
            skid_q <= data_in;
        end
    end

endmodule

//--- hdl/cache_bypass.sv
// Splits io requests from cache traffic onto one memory port and steers responses by tag
`timescale 1ns/1ps

module cache_bypass import cache_pkg::*; #(
    parameter int  NUM_PORTS = 2,
    localparam int IDX_W     = (NUM_PORTS > 1) ? $clog2(NUM_PORTS) : 1
) (
    input  logic                  clk,
    input  logic                  rst,

    // Core side
    input  logic [NUM_PORTS-1:0]  core_in_valid,
    input  core_req_t [NUM_PORTS-1:0] core_in_req,
    output logic [NUM_PORTS-1:0]  core_in_ready,
    output logic [NUM_PORTS-1:0]  core_in_rsp_valid,
    output core_rsp_t [NUM_PORTS-1:0] core_in_rsp,
    input  logic [NUM_PORTS-1:0]  core_in_rsp_ready,

    // Cache core ports
    output logic [NUM_PORTS-1:0]  cache_req_valid,
    output core_req_t [NUM_PORTS-1:0] cache_req,
    input  logic [NUM_PORTS-1:0]  cache_req_ready,
    input  logic [NUM_PORTS-1:0]  cache_rsp_valid,
    input  core_rsp_t [NUM_PORTS-1:0] cache_rsp,
    output logic [NUM_PORTS-1:0]  cache_rsp_ready,

    // Cache memory port
    input  logic                  cmem_req_valid,
    input  mem_req_t              cmem_req,
    output logic                  cmem_req_ready,
    output logic                  cmem_rsp_valid,
    output mem_rsp_t              cmem_rsp,
    input  logic                  cmem_rsp_ready,

    // Memory side
    output logic                  mem_req_valid,
    output mem_req_t              mem_req,
    input  logic                  mem_req_ready,
    input  logic                  mem_rsp_valid,
    input  mem_rsp_t              mem_rsp,
    output logic                  mem_rsp_ready
);

    logic [NUM_PORTS-1:0] io_valid;
    logic [NUM_PORTS-1:0] io_sel;
    logic [IDX_W-1:0]     io_idx;
    logic                 io_grant;
    logic                 io_ready;
    core_req_t            io_req;
    logic [WSEL_BITS-1:0] io_wsel;
    line_t                io_data;
    line_byteen_t         io_byteen;

    mem_req_t             mreq_in;
    logic                 mreq_valid_in;
    logic                 mreq_ready_in;

    logic                 rsp_bypass;
    logic [IDX_W-1:0]     rsp_idx;
    logic [WSEL_BITS-1:0] rsp_wsel;
    logic [NUM_PORTS-1:0] crsp_valid_in;
    core_rsp_t [NUM_PORTS-1:0] crsp_in;
    logic [NUM_PORTS-1:0] crsp_ready;

    for (genvar i = 0; i < NUM_PORTS; i++) begin : g_split
        assign io_valid[i]        = core_in_valid[i] && core_in_req[i].io;
        assign cache_req_valid[i] = core_in_valid[i] && !core_in_req[i].io;
        assign cache_req[i]       = core_in_req[i];
        assign core_in_ready[i]   = io_valid[i] ? (io_ready && io_sel[i]) : cache_req_ready[i];
    end

    req_arbiter #(
        .NUM_PORTS (NUM_PORTS)
    ) io_arb (
        .clk          (clk),
        .rst          (rst),
        .requests     (io_valid),
        .grant_index  (io_idx),
        .grant_onehot (io_sel),
        .grant_valid  (io_grant),
        .grant_ready  (io_ready)
    );

    // Cache line traffic goes first
    assign io_ready = !cmem_req_valid && mreq_ready_in;

    assign io_req  = core_in_req[io_idx];
    assign io_wsel = io_req.addr[WSEL_BITS-1:0];

    always_comb begin
        io_data   = '0;
        io_byteen = '0;
        io_data[io_wsel*WORD_BITS +: WORD_BITS]       = io_req.data;
        io_byteen[io_wsel*WORD_BITS/8 +: WORD_BITS/8] = io_req.byteen;
    end

    always_comb begin
        if (cmem_req_valid) begin
            mreq_in = cmem_req;
            mreq_in.tag[BYPASS_BIT] = 1'b0;
        end else begin
            mreq_in.rw     = io_req.rw;
            mreq_in.addr   = io_req.addr[15:WSEL_BITS];
            mreq_in.data   = io_data;
            mreq_in.byteen = io_byteen;
            mreq_in.tag    = {1'b1, io_idx[0], io_wsel, io_req.tag};
        end
    end

    assign mreq_valid_in  = cmem_req_valid || io_grant;
    assign cmem_req_ready = mreq_ready_in;

    elastic_buffer #(
        .DATAW ($bits(mem_req_t))
    ) mem_req_buf (
        .clk       (clk),
        .rst       (rst),
        .valid_in  (mreq_valid_in),
        .ready_in  (mreq_ready_in),
        .data_in   (mreq_in),
        .valid_out (mem_req_valid),
        .ready_out (mem_req_ready),
        .data_out  (mem_req)
    );

    assign rsp_bypass = mem_rsp_valid && mem_rsp.tag[BYPASS_BIT];
    assign rsp_idx    = IDX_W'(mem_rsp.tag[PORT_BIT]);
    assign rsp_wsel   = mem_rsp.tag[5:4];

    for (genvar i = 0; i < NUM_PORTS; i++) begin : g_rsp
        assign crsp_valid_in[i] = cache_rsp_valid[i]
                                  || (rsp_bypass && rsp_idx == IDX_W'(i));
        assign crsp_in[i].data  = cache_rsp_valid[i] ? cache_rsp[i].data
                                  : mem_rsp.data[rsp_wsel*WORD_BITS +: WORD_BITS];
        assign crsp_in[i].tag   = cache_rsp_valid[i] ? cache_rsp[i].tag : mem_rsp.tag[3:0];
        assign cache_rsp_ready[i] = crsp_ready[i];

        elastic_buffer #(
            .DATAW ($bits(core_rsp_t))
        ) core_rsp_buf (
            .clk       (clk),
            .rst       (rst),
            .valid_in  (crsp_valid_in[i]),
            .ready_in  (crsp_ready[i]),
            .data_in   (crsp_in[i]),
            .valid_out (core_in_rsp_valid[i]),
            .ready_out (core_in_rsp_ready[i]),
            .data_out  (core_in_rsp[i])
        );
    end

    assign cmem_rsp_valid = mem_rsp_valid && !mem_rsp.tag[BYPASS_BIT];
    assign cmem_rsp.data  = mem_rsp.data;
    assign cmem_rsp.tag   = {1'b0, mem_rsp.tag[BYPASS_BIT-1:0]};

    // A bypass response waits while the cache answers the same port
    assign mem_rsp_ready = rsp_bypass ? (!cache_rsp_valid[rsp_idx] && crsp_ready[rsp_idx])
                                      : cmem_rsp_ready;

endmodule

//--- hdl/line_cache.sv
// Direct-mapped write-through cache serving the core ports one request at a time
`timescale 1ns/1ps

module line_cache import cache_pkg::*; #(
    parameter int  NUM_PORTS = 2,
    parameter int  NUM_LINES = 8,
    localparam int IDX_W     = (NUM_PORTS > 1) ? $clog2(NUM_PORTS) : 1,
    localparam int SET_W     = $clog2(NUM_LINES),
    localparam int TAG_W     = $bits(line_addr_t) - SET_W
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic [NUM_PORTS-1:0]  req_valid,
    input  core_req_t [NUM_PORTS-1:0] req,
    output logic [NUM_PORTS-1:0]  req_ready,
    output logic [NUM_PORTS-1:0]  rsp_valid,
    output core_rsp_t [NUM_PORTS-1:0] rsp,
    input  logic [NUM_PORTS-1:0]  rsp_ready,
    output logic                  mem_req_valid,
    output mem_req_t              mem_req,
    input  logic                  mem_req_ready,
    input  logic                  mem_rsp_valid,
    input  mem_rsp_t              mem_rsp,
    output logic                  mem_rsp_ready
);

    cache_state_e         state;
    core_req_t            req_q;
    logic [IDX_W-1:0]     port_q;

    line_t                data_mem [NUM_LINES];
    logic [TAG_W-1:0]     tag_mem [NUM_LINES];
    logic [NUM_LINES-1:0] valid_bits;

    logic [IDX_W-1:0]     grant_idx;
    logic [NUM_PORTS-1:0] grant_sel;
    logic                 grant_valid;
    logic                 idle;
    logic                 accept;

    line_addr_t           line_addr;
    logic [SET_W-1:0]     set_idx;
    logic [WSEL_BITS-1:0] wsel;
    logic                 hit;
    logic                 rsp_fire;
    logic                 rsp_now;

    req_arbiter #(
        .NUM_PORTS (NUM_PORTS)
    ) port_arb (
        .clk          (clk),
        .rst          (rst),
        .requests     (req_valid),
        .grant_index  (grant_idx),
        .grant_onehot (grant_sel),
        .grant_valid  (grant_valid),
        .grant_ready  (idle)
    );

    assign idle   = (state == IDLE);
    assign accept = idle && grant_valid;

    assign line_addr = req_q.addr[15:WSEL_BITS];
    assign set_idx   = line_addr[SET_W-1:0];
    assign wsel      = req_q.addr[WSEL_BITS-1:0];
    assign hit       = valid_bits[set_idx] && (tag_mem[set_idx] == line_addr[$bits(line_addr_t)-1:SET_W]);

    // Read hits answer from LOOKUP, writes once memory acknowledges
    assign rsp_now  = (state == LOOKUP && hit && !req_q.rw)
                      || (state == WRITE_WAIT && mem_rsp_valid);
    assign rsp_fire = rsp_now && rsp_ready[port_q];

    for (genvar i = 0; i < NUM_PORTS; i++) begin : g_port
        assign req_ready[i] = idle && (grant_sel[i] || !req_valid[i]);
        assign rsp_valid[i] = rsp_now && (port_q == IDX_W'(i));
        assign rsp[i].data  = req_q.rw ? '0 : data_mem[set_idx][wsel*WORD_BITS +: WORD_BITS];
        assign rsp[i].tag   = req_q.tag;
    end

    assign mem_req_valid = (state == FILL_REQ) || (state == WRITE_REQ);
    assign mem_rsp_ready = (state == FILL_WAIT) || (state == WRITE_WAIT && rsp_ready[port_q]);

    always_comb begin
        mem_req.rw     = (state == WRITE_REQ);
        mem_req.addr   = line_addr;
        mem_req.data   = '0;
        mem_req.byteen = '0;
        mem_req.tag    = {1'b0, port_q[0], wsel, req_q.tag};
        if (state == WRITE_REQ) begin
            mem_req.data[wsel*WORD_BITS +: WORD_BITS]       = req_q.data;
            mem_req.byteen[wsel*WORD_BITS/8 +: WORD_BITS/8] = req_q.byteen;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= IDLE;
            valid_bits <= '0;
        end else begin
            case (state)
                IDLE:       if (accept) state <= LOOKUP;
                LOOKUP: begin
                    if (req_q.rw) begin
                        state <= WRITE_REQ;
                    end else if (!hit) begin
                        state <= FILL_REQ;
                    end else if (rsp_fire) begin
                        state <= IDLE;
                    end
                end
                FILL_REQ:   if (mem_req_ready) state <= FILL_WAIT;
                FILL_WAIT: begin
                    if (mem_rsp_valid) begin
                        valid_bits[set_idx] <= 1'b1;
                        state <= LOOKUP;
                    end
                end
                WRITE_REQ:  if (mem_req_ready) state <= WRITE_WAIT;
                WRITE_WAIT: if (rsp_fire) state <= IDLE;
                default:    state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            req_q  <= req[grant_idx];
            port_q <= grant_idx;
        end
        if (state == FILL_WAIT && mem_rsp_valid) begin
            data_mem[set_idx] <= mem_rsp.data;
            tag_mem[set_idx]  <= line_addr[$bits(line_addr_t)-1:SET_W];
        end
        // Write hit keeps the cached copy current
        if (state == LOOKUP && req_q.rw && hit) begin
            for (int b = 0; b < WORD_BITS / 8; b++) begin
                if (req_q.byteen[b]) begin
                    data_mem[set_idx][(wsel*WORD_BITS/8 + b)*8 +: 8] <= req_q.data[b*8 +: 8];
                end
            end
        end
    end

endmodule

//--- hdl/mem_subsys.sv
// Top level of the cached memory subsystem joining core ports, bypass, cache and memory
`timescale 1ns/1ps

module mem_subsys import cache_pkg::*; #(
    parameter int NUM_PORTS = 2,
    parameter int NUM_LINES = 8
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic [NUM_PORTS-1:0]  core_req_valid,
    input  core_req_t [NUM_PORTS-1:0] core_req,
    output logic [NUM_PORTS-1:0]  core_req_ready,
    output logic [NUM_PORTS-1:0]  core_rsp_valid,
    output core_rsp_t [NUM_PORTS-1:0] core_rsp,
    input  logic [NUM_PORTS-1:0]  core_rsp_ready,
    output logic                  mem_req_valid,
    output mem_req_t              mem_req,
    input  logic                  mem_req_ready,
    input  logic                  mem_rsp_valid,
    input  mem_rsp_t              mem_rsp,
    output logic                  mem_rsp_ready
);

    logic [NUM_PORTS-1:0]      cache_req_valid;
    core_req_t [NUM_PORTS-1:0] cache_req;
    logic [NUM_PORTS-1:0]      cache_req_ready;
    logic [NUM_PORTS-1:0]      cache_rsp_valid;
    core_rsp_t [NUM_PORTS-1:0] cache_rsp;
    logic [NUM_PORTS-1:0]      cache_rsp_ready;

    logic                      cmem_req_valid;
    mem_req_t                  cmem_req;
    logic                      cmem_req_ready;
    logic                      cmem_rsp_valid;
    mem_rsp_t                  cmem_rsp;
    logic                      cmem_rsp_ready;

    cache_bypass #(
        .NUM_PORTS (NUM_PORTS)
    ) bypass (
        .clk               (clk),
        .rst               (rst),
        .core_in_valid     (core_req_valid),
        .core_in_req       (core_req),
        .core_in_ready     (core_req_ready),
        .core_in_rsp_valid (core_rsp_valid),
        .core_in_rsp       (core_rsp),
        .core_in_rsp_ready (core_rsp_ready),
        .cache_req_valid   (cache_req_valid),
        .cache_req         (cache_req),
        .cache_req_ready   (cache_req_ready),
        .cache_rsp_valid   (cache_rsp_valid),
        .cache_rsp         (cache_rsp),
        .cache_rsp_ready   (cache_rsp_ready),
        .cmem_req_valid    (cmem_req_valid),
        .cmem_req          (cmem_req),
        .cmem_req_ready    (cmem_req_ready),
        .cmem_rsp_valid    (cmem_rsp_valid),
        .cmem_rsp          (cmem_rsp),
        .cmem_rsp_ready    (cmem_rsp_ready),
        .mem_req_valid     (mem_req_valid),
        .mem_req           (mem_req),
        .mem_req_ready     (mem_req_ready),
        .mem_rsp_valid     (mem_rsp_valid),
        .mem_rsp           (mem_rsp),
        .mem_rsp_ready     (mem_rsp_ready)
    );

    line_cache #(
        .NUM_PORTS (NUM_PORTS),
        .NUM_LINES (NUM_LINES)
    ) cache (
        .clk           (clk),
        .rst           (rst),
        .req_valid     (cache_req_valid),
        .req           (cache_req),
        .req_ready     (cache_req_ready),
        .rsp_valid     (cache_rsp_valid),
        .rsp           (cache_rsp),
        .rsp_ready     (cache_rsp_ready),
        .mem_req_valid (cmem_req_valid),
        .mem_req       (cmem_req),
        .mem_req_ready (cmem_req_ready),
        .mem_rsp_valid (cmem_rsp_valid),
        .mem_rsp       (cmem_rsp),
        .mem_rsp_ready (cmem_rsp_ready)
    );

endmodule

//--- testbench/tb_mem_subsys.sv
// Testbench for mem_subsys that plays request cases from mem_cases.txt against a memory model
`timescale 1ns/1ps

module tb_mem_subsys import cache_pkg::*; ();

    localparam int NUM_PORTS = 2;
    localparam int NUM_LINES = 8;
    localparam int MAX_CASES = 64;
    localparam int TIMEOUT   = 500;

    logic                      clk = 1'b0;
    logic                      rst;
    logic [NUM_PORTS-1:0]      core_req_valid;
    core_req_t [NUM_PORTS-1:0] core_req;
    logic [NUM_PORTS-1:0]      core_req_ready;
    logic [NUM_PORTS-1:0]      core_rsp_valid;
    core_rsp_t [NUM_PORTS-1:0] core_rsp;
    logic [NUM_PORTS-1:0]      core_rsp_ready;
    logic                      mem_req_valid;
    mem_req_t                  mem_req;
    logic                      mem_req_ready;
    logic                      mem_rsp_valid;
    mem_rsp_t                  mem_rsp;
    logic                      mem_rsp_ready;

    string        c_name [MAX_CASES];
    string        c_mode [MAX_CASES];
    int           c_port [MAX_CASES];
    int           c_rw [MAX_CASES];
    int           c_io [MAX_CASES];
    word_addr_t   c_addr [MAX_CASES];
    word_t        c_data [MAX_CASES];
    byteen_t      c_be [MAX_CASES];
    word_t        c_exp [MAX_CASES];
    int           num_cases;

    // Memory model state
    word_t        mem_words [65536];
    line_t        pq_data [$];
    mem_tag_t     pq_tag [$];
    int           pq_due [$];
    int           cycle;
    int           bypass_count;
    int           cache_count;
    line_byteen_t last_wr_be;
    logic         stress_on;
    logic         stress_q;
    logic [15:0]  lfsr_q;

    int           acc_count [NUM_PORTS];
    int           rsp_count [NUM_PORTS];
    word_t        rsp_data [NUM_PORTS];
    core_tag_t    rsp_tag [NUM_PORTS];
    int           issued [NUM_PORTS];

    // Which lines the cache should hold
    logic         ref_valid [NUM_LINES];
    line_addr_t   ref_line [NUM_LINES];
    int           exp_bypass;
    int           exp_cache;
    int           errors;
    int           tests_failed;
    bit           aborted;

    mem_subsys #(
        .NUM_PORTS (NUM_PORTS),
        .NUM_LINES (NUM_LINES)
    ) uut (
        .clk            (clk),
        .rst            (rst),
        .core_req_valid (core_req_valid),
        .core_req       (core_req),
        .core_req_ready (core_req_ready),
        .core_rsp_valid (core_rsp_valid),
        .core_rsp       (core_rsp),
        .core_rsp_ready (core_rsp_ready),
        .mem_req_valid  (mem_req_valid),
        .mem_req        (mem_req),
        .mem_req_ready  (mem_req_ready),
        .mem_rsp_valid  (mem_rsp_valid),
        .mem_rsp        (mem_rsp),
        .mem_rsp_ready  (mem_rsp_ready)
    );

    initial begin
        forever #10 clk = ~clk;
    end

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic int rand_bits(input int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_next(lfsr_q);
            v = (v << 1) | int'(lfsr_q[0]);
        end
        return v;
    endfunction

    task automatic check_value(input string what, input logic [31:0] exp,
                               input logic [31:0] act);
        if (exp !== act) begin
            $display("Error %s: expected %h, got %h", what, exp, act);
            errors++;
        end
    endtask

    // Memory accepts requests and queues one response each after 1 to 4 cycles
    always @(posedge clk) begin
        line_t      rd_line;
        line_addr_t la;
        cycle++;
        stress_q = stress_on;
        if (mem_rsp_valid && mem_rsp_ready) begin
            void'(pq_data.pop_front());
            void'(pq_tag.pop_front());
            void'(pq_due.pop_front());
        end
        if (mem_req_valid && mem_req_ready) begin
            la = mem_req.addr;
            rd_line = '0;
            if (mem_req.tag[BYPASS_BIT]) begin
                bypass_count++;
            end else begin
                cache_count++;
            end
            if (mem_req.rw) begin
                last_wr_be = mem_req.byteen;
                for (int b = 0; b < 16; b++) begin
                    if (mem_req.byteen[b]) begin
                        mem_words[{la, 2'(b / 4)}][(b % 4)*8 +: 8] = mem_req.data[b*8 +: 8];
                    end
                end
            end else begin
                for (int w = 0; w < 4; w++) begin
                    rd_line[w*32 +: 32] = mem_words[{la, 2'(w)}];
                end
            end
            pq_data.push_back(rd_line);
            pq_tag.push_back(mem_req.tag);
            pq_due.push_back(cycle + 1 + rand_bits(2));
        end
    end

    always @(negedge clk) begin
        mem_req_ready = stress_q ? 1'(rand_bits(1)) : 1'b1;
        if (pq_due.size() > 0 && pq_due[0] <= cycle) begin
            mem_rsp_valid = 1'b1;
            mem_rsp.data  = pq_data[0];
            mem_rsp.tag   = pq_tag[0];
        end else begin
            mem_rsp_valid = 1'b0;
            mem_rsp       = '0;
        end
    end

    // Core side handshakes
    always @(posedge clk) begin
        for (int p = 0; p < NUM_PORTS; p++) begin
            if (!rst && core_req_valid[p] && core_req_ready[p]) begin
                acc_count[p]++;
            end
            if (!rst && core_rsp_valid[p] && core_rsp_ready[p]) begin
                rsp_count[p]++;
                rsp_data[p] = core_rsp[p].data;
                rsp_tag[p]  = core_rsp[p].tag;
            end
        end
    end

    task automatic load_cases();
        int    fd;
        int    cnt;
        string text;
        num_cases = 0;
        fd = $fopen("testbench/mem_cases.txt", "r");
        if (fd == 0) begin
            $display("Could not open testbench/mem_cases.txt");
            aborted = 1'b1;
            return;
        end
        while (!$feof(fd) && num_cases < MAX_CASES) begin
            text = "";
            void'($fgets(text, fd));
            if (text.len() < 2 || text.getc(0) == "#") begin
                continue;
            end
            cnt = $sscanf(text, "%s %s %d %d %d %h %h %h %h", c_name[num_cases],
                          c_mode[num_cases], c_port[num_cases], c_rw[num_cases],
                          c_io[num_cases], c_addr[num_cases], c_data[num_cases],
                          c_be[num_cases], c_exp[num_cases]);
            if (cnt != 9) begin
                $display("Malformed case line: %s", text);
                aborted = 1'b1;
            end else begin
                num_cases++;
            end
        end
        $fclose(fd);
    endtask

    // Expected memory traffic of a write-through cache that does not allocate on writes
    task automatic predict(input int k);
        int         set_i;
        line_addr_t la;
        la = c_addr[k][15:WSEL_BITS];
        set_i = int'(la) % NUM_LINES;
        if (c_io[k] != 0) begin
            exp_bypass++;
        end else if (c_rw[k] != 0) begin
            exp_cache++;
        end else if (!(ref_valid[set_i] && ref_line[set_i] == la)) begin
            exp_cache++;
            ref_valid[set_i] = 1'b1;
            ref_line[set_i]  = la;
        end
    endtask

    task automatic drive_req(input int k);
        int p;
        p = c_port[k];
        core_req[p].rw     = (c_rw[k] != 0);
        core_req[p].io     = (c_io[k] != 0);
        core_req[p].addr   = c_addr[k];
        core_req[p].data   = c_data[k];
        core_req[p].byteen = c_be[k];
        core_req[p].tag    = core_tag_t'(k % 16);
        core_req_valid[p]  = 1'b1;
        issued[p]++;
    endtask

    task automatic run_group(input int first, input int n);
        int                   p;
        int                   hold;
        int                   wait_n;
        int                   err_before;
        bit                   bp;
        bit                   done;
        int                   acc_goal [NUM_PORTS];
        int                   rsp_goal [NUM_PORTS];
        logic [NUM_PORTS-1:0] pend;
        err_before = errors;
        bp = (c_mode[first] == "b");
        hold = c_port[first];
        pend = '0;
        done = 1'b0;
        for (p = 0; p < NUM_PORTS; p++) begin
            acc_goal[p] = acc_count[p];
            rsp_goal[p] = rsp_count[p];
        end
        @(negedge clk);
        stress_on = bp;
        for (int k = first; k < first + n; k++) begin
            predict(k);
            drive_req(k);
            acc_goal[c_port[k]]++;
            rsp_goal[c_port[k]]++;
            pend[c_port[k]] = 1'b1;
        end
        if (bp) begin
            core_rsp_ready[hold] = 1'b0;
        end
        wait_n = 0;
        while (pend != 0 && wait_n < TIMEOUT) begin
            @(negedge clk);
            wait_n++;
            for (p = 0; p < NUM_PORTS; p++) begin
                if (pend[p] && acc_count[p] == acc_goal[p]) begin
                    core_req_valid[p] = 1'b0;
                    pend[p] = 1'b0;
                end
            end
        end
        if (pend != 0) begin
            $display("Timeout: request of %s was never accepted", c_name[first]);
            aborted = 1'b1;
        end
        wait_n = 0;
        while (!aborted && !done && wait_n < TIMEOUT) begin
            @(negedge clk);
            wait_n++;
            done = 1'b1;
            for (p = 0; p < NUM_PORTS; p++) begin
                if (rsp_count[p] < rsp_goal[p]) begin
                    done = 1'b0;
                end
            end
            // Stalled port is let go once the other port has its answer
            if (bp && rsp_count[1 - hold] == rsp_goal[1 - hold]) begin
                core_rsp_ready[hold] = 1'b1;
            end
        end
        if (!aborted && !done) begin
            $display("Timeout: no response for %s", c_name[first]);
            aborted = 1'b1;
        end
        stress_on = 1'b0;
        core_rsp_ready = '1;
        for (int k = first; k < first + n; k++) begin
            p = c_port[k];
            check_value(c_name[k], c_exp[k], rsp_data[p]);
            check_value({c_name[k], " tag"}, 32'(k % 16), 32'(rsp_tag[p]));
        end
        check_value({c_name[first], " bypass request count"}, exp_bypass, bypass_count);
        check_value({c_name[first], " cache request count"}, exp_cache, cache_count);
        if (n == 1 && c_rw[first] != 0) begin
            check_value({c_name[first], " write lanes"},
                        32'(line_byteen_t'(c_be[first]) << (4 * c_addr[first][1:0])),
                        32'(last_wr_be));
        end
        for (int k = first; k < first + n; k++) begin
            $display("%-14s %s", c_name[k], (errors == err_before) ? "ok" : "mismatch");
        end
        if (errors != err_before) begin
            tests_failed += n;
        end
    endtask

    initial begin
        int k;
        int err_before;
        lfsr_q = 16'd2206;
        rst = 1'b1;
        core_req_valid = '0;
        core_req = '0;
        core_rsp_ready = '1;
        mem_req_ready = 1'b1;
        mem_rsp_valid = 1'b0;
        mem_rsp = '0;
        stress_on = 1'b0;
        stress_q = 1'b0;
        cycle = 0;
        bypass_count = 0;
        cache_count = 0;
        last_wr_be = '0;
        errors = 0;
        tests_failed = 0;
        aborted = 1'b0;
        exp_bypass = 0;
        exp_cache = 0;
        for (int p = 0; p < NUM_PORTS; p++) begin
            acc_count[p] = 0;
            rsp_count[p] = 0;
            issued[p] = 0;
        end
        for (int l = 0; l < NUM_LINES; l++) begin
            ref_valid[l] = 1'b0;
        end
        for (int a = 0; a < 65536; a++) begin
            mem_words[a] = 32'h1000_0000 + a;
        end
        load_cases();
        repeat (5) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        err_before = errors;
        check_value("reset core_req_ready", 32'h3, 32'(core_req_ready));
        check_value("reset core_rsp_valid", 32'h0, 32'(core_rsp_valid));
        check_value("reset mem_req_valid", 32'h0, 32'(mem_req_valid));
        $display("%-14s %s", "reset", (errors == err_before) ? "ok" : "mismatch");
        if (errors != err_before) begin
            tests_failed++;
        end
        k = 0;
        while (k < num_cases && !aborted) begin
            if (c_mode[k] == "p" || c_mode[k] == "b") begin
                if (k + 1 >= num_cases || c_port[k] == c_port[k + 1]) begin
                    $display("Case %s needs a partner line on the other port", c_name[k]);
                    aborted = 1'b1;
                end else begin
                    run_group(k, 2);
                end
                k += 2;
            end else begin
                run_group(k, 1);
                k++;
            end
        end
        // Extra responses would show up here
        repeat (10) @(negedge clk);
        for (int p = 0; p < NUM_PORTS; p++) begin
            check_value($sformatf("port %0d response count", p), issued[p], rsp_count[p]);
        end
        $display("tests: %0d, failed: %0d, check errors: %0d",
                 num_cases + 1, tests_failed, errors);
        if (errors == 0 && !aborted) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

//--- compile.f
hdl/cache_pkg.sv
hdl/req_arbiter.sv
hdl/elastic_buffer.sv
hdl/cache_bypass.sv
hdl/line_cache.sv
hdl/mem_subsys.sv
testbench/tb_mem_subsys.sv

//--- testbench/mem_cases.txt
# name mode port rw io addr data byteen expected_read_data (addr, data, byteen, expected in hex)
# mode: s single, p issued with the next line, b like p with back-pressure, + partner line
rd_miss       s 0 0 0 0010 00000000 f 10000010
rd_hit        s 0 0 0 0010 00000000 f 10000010
rd_hit_p1     s 1 0 0 0011 00000000 f 10000011
wr_part       s 0 1 0 0012 aabbccdd 3 00000000
rd_merged     s 1 0 0 0012 00000000 f 1000ccdd
wr_miss       s 1 1 0 0040 11223344 c 00000000
rd_wr_miss    s 0 0 0 0040 00000000 f 11220040
rd_evict      s 0 0 0 0030 00000000 f 10000030
rd_refill     s 1 0 0 0013 00000000 f 10000013
io_rd         s 0 0 1 0100 00000000 f 10000100
io_rd_again   s 0 0 1 0100 00000000 f 10000100
io_wr         s 1 1 1 0101 deadbeef 1 00000000
io_rd_merged  s 1 0 1 0101 00000000 f 100001ef
io_rd_cached  s 0 0 1 0012 00000000 f 1000ccdd
dual_rd_a     p 0 0 1 0200 00000000 f 10000200
dual_rd_b     + 1 0 1 0302 00000000 f 10000302
dual_wr_a     p 0 1 1 0203 12345678 f 00000000
dual_wr_b     + 1 1 1 0303 87654321 f 00000000
dual_chk_a    p 0 0 1 0203 00000000 f 12345678
dual_chk_b    + 1 0 1 0303 00000000 f 87654321
mix_io        p 0 0 1 0400 00000000 f 10000400
mix_cache     + 1 0 0 0050 00000000 f 10000050
bp_miss       b 0 0 0 0060 00000000 f 10000060
bp_io         + 1 0 1 0500 00000000 f 10000500
bp_io_rd      b 0 0 1 0501 00000000 f 10000501
bp_wr_hit     + 1 1 0 0061 cafef00d f 00000000
bp_hit_a      b 0 0 0 0061 00000000 f cafef00d
bp_hit_b      + 1 0 0 0062 00000000 f 10000062
bp_io_wr      b 0 1 1 0600 0badf00d f 00000000
bp_refill     + 1 0 0 0011 00000000 f 10000011
